//--- apb_regs.sv
// APB slave for the test engine: run control, status, pass count and fault-log pop
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
   input  wire logic                   mem_clk90,
   input  wire logic                   mem_rst90,
   input  wire logic                   psel,
   input  wire logic                   penable,
   input  wire logic                   pwrite,
   input  wire memtest_pkg::apb_addr_t paddr,
   input  wire memtest_pkg::reg_t      pwdata,
   input  wire memtest_pkg::row_t      head_row,
   input  wire logic                   log_empty,
   input  wire logic                   log_full,
   input  wire logic                   overflow,
   input  wire memtest_pkg::pass_cnt_t pass_count,
   output memtest_pkg::reg_t           prdata,
   output logic                        pready,
   output logic                        pslverr,
   output logic                        run,
   output logic                        pop
);

   logic access;    // access phase of any transfer
   logic addr_ok;

   assign access = psel & penable;
   assign pready = 1'b1;   // zero wait states

   always_comb begin
      case (paddr)
         memtest_pkg::reg_ctrl_addr,
         memtest_pkg::reg_status_addr,
         memtest_pkg::reg_pass_addr,
         memtest_pkg::reg_fault_row_addr: addr_ok = 1'b1;
         default:                         addr_ok = 1'b0;
      endcase
   end

   assign pslverr = access & ~addr_ok;

   // a FAULT_ROW read consumes the head entry
   assign pop = access & ~pwrite & (paddr == memtest_pkg::reg_fault_row_addr) & ~log_empty;

   // --------------------
   // write side
   // --------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         run <= 1'b0;
      end else if (access & pwrite & (paddr == memtest_pkg::reg_ctrl_addr)) begin
         run <= pwdata[0];
      end
      // STATUS, PASS and FAULT_ROW writes fall through, no error
   end

   // --------------------
   // read mux
   // --------------------
   always_comb begin
      prdata = '0;
      if (psel & ~pwrite) begin
         case (paddr)
            memtest_pkg::reg_ctrl_addr:   prdata = {31'd0, run};
            memtest_pkg::reg_status_addr: prdata = {29'd0, overflow, log_full, log_empty};
            memtest_pkg::reg_pass_addr:   prdata = memtest_pkg::reg_t'(pass_count);
            memtest_pkg::reg_fault_row_addr: begin
               if (!log_empty) begin
                  prdata = memtest_pkg::reg_t'(head_row);   // 0 when nothing logged
               end
            end
            default: prdata = '0;   // unmapped reads 0
         endcase
      end
   end

endmodule

`default_nettype wire

//--- fault_log_fifo.sv
// circular buffer of failing row numbers with a sticky overflow flag, popped through the APB slave
`timescale 1ns/1ps
`default_nettype none

module fault_log_fifo #(
   parameter int unsigned FIFO_DEPTH = 16
) (
   input  wire logic                mem_clk90,
   input  wire logic                mem_rst90,
   input  wire logic                log_push,
   input  wire logic                pop,
   input  wire memtest_pkg::row_t   log_row,
   output memtest_pkg::row_t        head_row,
   output logic                     log_empty,
   output logic                     log_full,
   output logic                     overflow
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   memtest_pkg::row_t mem [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;   // occupancy
   logic              wr_ok;
   logic              rd_ok;

   assign log_empty = (count == '0);
   assign log_full  = (count == CNT_W'(FIFO_DEPTH));
   assign head_row  = mem[rd_ptr];

   assign wr_ok = log_push & ~log_full;   // push into a full log is dropped
   assign rd_ok = pop & ~log_empty;

   // storage
   always_ff @(posedge mem_clk90) begin
      if (wr_ok) begin
         mem[wr_ptr] <= log_row;
      end
   end

   // --------------------
   // pointers and count
   // --------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push and pop together
         endcase
         if (log_push & log_full) begin
            overflow <= 1'b1;   // held until reset
         end
      end
   end

endmodule

`default_nettype wire

//--- memtest_asserts.sv
// concurrent checks on the memory request handshake and the fault log, bound into memtest_top
`timescale 1ns/1ps
`default_nettype none

module memtest_asserts (
   input wire logic                   mem_clk90,
   input wire logic                   mem_rst90,
   input wire logic                   rd_mem_req,
   input wire memtest_pkg::mem_addr_t rd_mem_addr,
   input wire logic                   rd_mem_grant,
   input wire logic                   rd_data_valid,
   input wire logic                   log_push,
   input wire logic                   log_full,
   input wire logic                   overflow
);

   int fail_count = 0;   // failed assertion tally

   // request and address held until the grant
   req_hold: assert property (@(posedge mem_clk90) disable iff (mem_rst90)
      rd_mem_req && !rd_mem_grant |=> rd_mem_req && $stable(rd_mem_addr))
      else begin
         $error("rd_mem_req dropped or rd_mem_addr moved before grant");
         fail_count++;
      end

   no_req_in_burst: assert property (@(posedge mem_clk90) disable iff (mem_rst90)
      rd_data_valid |-> !rd_mem_req)
      else begin
         $error("rd_mem_req raised while beats stream");
         fail_count++;
      end

   // dropped entry must leave a trace
   push_when_full: assert property (@(posedge mem_clk90) disable iff (mem_rst90)
      log_push && log_full |=> overflow)
      else begin
         $error("push into full fault log without overflow");
         fail_count++;
      end

endmodule

`default_nettype wire

//--- memtest_pkg.sv
// shared types, sequencer states, APB register map and read pattern for the memory read-test engine
`default_nettype none

package memtest_pkg;

   // --------------------
   // memory side widths
   // --------------------
   typedef logic [12:0] row_t;        // row address
   typedef logic [9:0]  col_t;        // column address
   typedef logic [1:0]  bank_t;       // bank address
   typedef logic [24:0] mem_addr_t;   // {row, col, bank}
   typedef logic [9:0]  xfr_len_t;    // beats per burst
   typedef logic [31:0] beat_t;       // one read beat

   typedef logic [15:0] pass_cnt_t;   // completed passes, saturating

   // --------------------
   // APB side widths
   // --------------------
   typedef logic [3:0]  apb_addr_t;
   typedef logic [31:0] reg_t;

   // read request sequencer
   typedef enum logic [1:0] {
      st_idle       = 2'b00,
      st_wait_grant = 2'b01,   // request up, waiting for grant
      st_pre_xfr    = 2'b10,   // granted, waiting for first beat
      st_data_xfr   = 2'b11    // beats streaming
   } seq_state_t;

   // register offsets
   localparam apb_addr_t reg_ctrl_addr      = 4'h0;
   localparam apb_addr_t reg_status_addr    = 4'h4;
   localparam apb_addr_t reg_pass_addr      = 4'h8;
   localparam apb_addr_t reg_fault_row_addr = 4'hC;

   // expected content of every beat, byte 0 is the LSB
   localparam logic [7:0] pattern_byte0 = 8'h10;
   localparam logic [7:0] pattern_byte1 = 8'h86;
   localparam logic [7:0] pattern_byte2 = 8'hCB;
   localparam logic [7:0] pattern_byte3 = 8'hFD;

endpackage

`default_nettype wire

//--- memtest_top.sv
// top level of the memory read-test engine, connects APB slave, sequencer, checker and fault log
`timescale 1ns/1ps
`default_nettype none

module memtest_top #(
   parameter int unsigned LAST_ROW   = 'h2FF,
   parameter int unsigned XFR_LEN    = 512,
   parameter int unsigned FIFO_DEPTH = 16
) (
   input  wire logic                   mem_clk90,
   input  wire logic                   mem_rst90,

   // APB slave
   input  wire logic                   psel,
   input  wire logic                   penable,
   input  wire logic                   pwrite,
   input  wire memtest_pkg::apb_addr_t paddr,
   input  wire memtest_pkg::reg_t      pwdata,
   output memtest_pkg::reg_t           prdata,
   output logic                        pready,
   output logic                        pslverr,

   // memory read port
   output logic                        rd_mem_req,
   output memtest_pkg::mem_addr_t      rd_mem_addr,
   output memtest_pkg::xfr_len_t       rd_xfr_len,
   input  wire logic                   rd_mem_grant,
   input  wire logic                   rd_data_valid,
   input  wire memtest_pkg::beat_t     rd_data
);

   // --------------------
   // internal links
   // --------------------
   logic                   run;
   logic                   pop;
   logic                   row_start;
   memtest_pkg::row_t      cur_row;
   logic                   log_push;
   memtest_pkg::row_t      log_row;
   memtest_pkg::row_t      head_row;
   logic                   log_empty;
   logic                   log_full;
   logic                   overflow;
   memtest_pkg::pass_cnt_t pass_count;

   apb_regs u_apb_regs (
      .mem_clk90  (mem_clk90),
      .mem_rst90  (mem_rst90),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .head_row   (head_row),
      .log_empty  (log_empty),
      .log_full   (log_full),
      .overflow   (overflow),
      .pass_count (pass_count),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .run        (run),
      .pop        (pop)
   );

   row_sequencer #(
      .LAST_ROW (LAST_ROW),
      .XFR_LEN  (XFR_LEN)
   ) u_row_sequencer (
      .mem_clk90     (mem_clk90),
      .mem_rst90     (mem_rst90),
      .run           (run),
      .rd_mem_grant  (rd_mem_grant),
      .rd_data_valid (rd_data_valid),
      .rd_mem_req    (rd_mem_req),
      .row_start     (row_start),
      .rd_mem_addr   (rd_mem_addr),
      .rd_xfr_len    (rd_xfr_len),
      .cur_row       (cur_row),
      .pass_count    (pass_count)
   );

   pattern_checker u_pattern_checker (
      .mem_clk90     (mem_clk90),
      .mem_rst90     (mem_rst90),
      .row_start     (row_start),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data),
      .cur_row       (cur_row),
      .log_push      (log_push),
      .log_row       (log_row)
   );

   fault_log_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fault_log_fifo (
      .mem_clk90 (mem_clk90),
      .mem_rst90 (mem_rst90),
      .log_push  (log_push),
      .pop       (pop),
      .log_row   (log_row),
      .head_row  (head_row),
      .log_empty (log_empty),
      .log_full  (log_full),
      .overflow  (overflow)
   );

endmodule

`default_nettype wire

//--- pattern_checker.sv
// compares each returned beat with the fixed pattern and requests one fault-log entry per bad row
`timescale 1ns/1ps
`default_nettype none

module pattern_checker (
   input  wire logic                mem_clk90,
   input  wire logic                mem_rst90,
   input  wire logic                row_start,
   input  wire logic                rd_data_valid,
   input  wire memtest_pkg::beat_t  rd_data,
   input  wire memtest_pkg::row_t   cur_row,
   output logic                     log_push,
   output memtest_pkg::row_t        log_row
);

   logic [3:0] byte_bad;     // per-byte compare result
   logic       mismatch;
   logic       row_failed;   // sticky until the next row starts
   logic       first_fail;

   // byte by byte against the pattern
   always_comb begin
      byte_bad[0] = (rd_data[7:0]   != memtest_pkg::pattern_byte0);
      byte_bad[1] = (rd_data[15:8]  != memtest_pkg::pattern_byte1);
      byte_bad[2] = (rd_data[23:16] != memtest_pkg::pattern_byte2);
      byte_bad[3] = (rd_data[31:24] != memtest_pkg::pattern_byte3);
   end

   assign mismatch   = rd_data_valid & (|byte_bad);
   assign first_fail = mismatch & ~row_failed;

   // --------------------
   // one push per row
   // --------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         row_failed <= 1'b0;
         log_push   <= 1'b0;
      end else begin
         log_push <= first_fail;   // lands one cycle after the bad beat
         if (row_start) begin
            row_failed <= 1'b0;
         end else if (mismatch) begin
            row_failed <= 1'b1;
         end
      end
   end

   // row number travels with the push
   always_ff @(posedge mem_clk90) begin
      if (first_fail) begin
         log_row <= cur_row;
      end
   end

endmodule

`default_nettype wire

//--- project.f
memtest_pkg.sv
row_sequencer.sv
pattern_checker.sv
fault_log_fifo.sv
apb_regs.sv
memtest_top.sv
memtest_asserts.sv
tb_memtest.sv

//--- row_sequencer.sv
// walks rows 0..LAST_ROW, requests one read burst per row, tracks it to its end and counts passes
`timescale 1ns/1ps
`default_nettype none

module row_sequencer #(
   parameter int unsigned LAST_ROW = 'h2FF,
   parameter int unsigned XFR_LEN  = 512
) (
   input  wire logic                mem_clk90,
   input  wire logic                mem_rst90,
   input  wire logic                run,
   input  wire logic                rd_mem_grant,
   input  wire logic                rd_data_valid,
   output logic                     rd_mem_req,
   output logic                     row_start,
   output memtest_pkg::mem_addr_t   rd_mem_addr,
   output memtest_pkg::xfr_len_t    rd_xfr_len,
   output memtest_pkg::row_t        cur_row,
   output memtest_pkg::pass_cnt_t   pass_count
);

   memtest_pkg::seq_state_t state;
   memtest_pkg::row_t       next_row;     // row of the next request
   logic                    run_1d;
   logic                    xfr_done;     // pulse, one cycle after valid falls
   logic                    go;
   logic                    burst_end;

   // start on the run edge, or keep going after each burst while run stays set
   assign go = (run & ~run_1d) | (xfr_done & run);

   assign burst_end = (state == memtest_pkg::st_data_xfr) & ~rd_data_valid;

   // column and bank fixed at 0, one full row per burst
   assign rd_mem_addr = {cur_row, memtest_pkg::col_t'(0), memtest_pkg::bank_t'(0)};
   assign rd_xfr_len  = memtest_pkg::xfr_len_t'(XFR_LEN);

   // --------------------
   // request FSM
   // --------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         state      <= memtest_pkg::st_idle;
         rd_mem_req <= 1'b0;
         row_start  <= 1'b0;
         xfr_done   <= 1'b0;
         run_1d     <= 1'b0;
         cur_row    <= '0;
      end else begin
         run_1d    <= run;
         row_start <= 1'b0;   // single-cycle pulses by default
         xfr_done  <= 1'b0;
         case (state)
            memtest_pkg::st_idle: begin
               if (go) begin
                  state      <= memtest_pkg::st_wait_grant;
                  rd_mem_req <= 1'b1;
                  row_start  <= 1'b1;
                  cur_row    <= next_row;
               end
            end
            memtest_pkg::st_wait_grant: begin
               // no timeout, a stalled grant just holds the request
               if (rd_mem_grant) begin
                  state      <= memtest_pkg::st_pre_xfr;
                  rd_mem_req <= 1'b0;
               end
            end
            memtest_pkg::st_pre_xfr: begin
               if (rd_data_valid) begin
                  state <= memtest_pkg::st_data_xfr;
               end
            end
            memtest_pkg::st_data_xfr: begin
               if (burst_end) begin   // first gap closes the burst
                  state    <= memtest_pkg::st_idle;
                  xfr_done <= 1'b1;
               end
            end
            default: state <= memtest_pkg::st_idle;
         endcase
      end
   end

   // --------------------
   // row and pass counters
   // --------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst90) begin
         next_row   <= '0;
         pass_count <= '0;
      end else if (burst_end) begin
         if (cur_row == memtest_pkg::row_t'(LAST_ROW)) begin
            next_row <= '0;   // wrap, one pass done
            if (pass_count != '1) begin
               pass_count <= pass_count + 1'b1;
            end
         end else begin
            next_row <= cur_row + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_memtest.sv
// directed testbench for memtest_top, models the memory read port and checks the APB registers
`timescale 1ns/1ps
`default_nettype none

module tb_memtest;

   localparam int unsigned LAST_ROW   = 3;
   localparam int unsigned XFR_LEN    = 8;
   localparam int unsigned FIFO_DEPTH = 4;
   localparam memtest_pkg::beat_t good_beat = 32'hFDCB8610;   // byte 0 in the LSB

   logic mem_clk90, mem_rst90, psel, penable, pwrite, pready, pslverr;
   logic rd_mem_req, rd_mem_grant, rd_data_valid;
   memtest_pkg::apb_addr_t paddr;
   memtest_pkg::reg_t      pwdata, prdata;
   memtest_pkg::mem_addr_t rd_mem_addr;
   memtest_pkg::xfr_len_t  rd_xfr_len;
   memtest_pkg::beat_t     rd_data;
   int                     err_count = 0;
   int                     check_count = 0;
   int                     test_errs;
   string                  cur_test;
   logic                   last_err;        // pslverr of the latest APB access
   logic [31:0]            rng = 32'h8ed;
   memtest_pkg::row_t      exp_rows[$];     // rows expected in the fault log

   memtest_top #(.LAST_ROW(LAST_ROW), .XFR_LEN(XFR_LEN), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

   bind memtest_top memtest_asserts u_asserts (.*);

   initial begin
      mem_clk90 = 1'b0;
      forever #10 mem_clk90 = ~mem_clk90;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_reg(input string what, input memtest_pkg::reg_t exp, act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_addr(input string what, input memtest_pkg::mem_addr_t exp, act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_len(input string what, input memtest_pkg::xfr_len_t exp, act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   // --------------------
   // APB master
   // --------------------
   task automatic apb_xfer(input logic wr, input memtest_pkg::apb_addr_t addr,
                           input memtest_pkg::reg_t wdata, output memtest_pkg::reg_t rdata);
      @(negedge mem_clk90);
      psel   = 1'b1;
      pwrite = wr;
      paddr  = addr;
      pwdata = wdata;
      @(negedge mem_clk90);
      penable = 1'b1;
      #5;   // mid access phase before the access edge
      rdata    = prdata;
      last_err = pslverr;
      check_reg("pready", 32'h1, memtest_pkg::reg_t'(pready));
      @(negedge mem_clk90);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input memtest_pkg::apb_addr_t addr, input memtest_pkg::reg_t data);
      memtest_pkg::reg_t ignored;
      apb_xfer(1'b1, addr, data, ignored);
   endtask

   task automatic apb_read(input memtest_pkg::apb_addr_t addr, output memtest_pkg::reg_t data);
      apb_xfer(1'b0, addr, '0, data);
   endtask

   task automatic read_expect(input string what, input memtest_pkg::apb_addr_t addr,
                              input memtest_pkg::reg_t exp);
      memtest_pkg::reg_t data;
      apb_read(addr, data);
      check_reg(what, exp, data);
   endtask

   // --------------------
   // memory read port model
   // --------------------
   task automatic wait_request();
      int n = 0;
      while (!rd_mem_req && n < 100) begin
         @(negedge mem_clk90);
         n++;
      end
      if (!rd_mem_req) begin
         $display("%s: no rd_mem_req within 100 cycles", cur_test);
         $display("STATUS: FAIL");
         $finish;
      end
   endtask

   // bad marks the beats that get one corrupted byte
   // stop clears run ahead of the grant
   task automatic serve_burst(input memtest_pkg::row_t row, input logic [7:0] bad,
                              input logic stop);
      logic [31:0] r;
      wait_request();
      check_addr("rd_mem_addr", memtest_pkg::mem_addr_t'({row, 12'h000}), rd_mem_addr);
      check_len("rd_xfr_len", memtest_pkg::xfr_len_t'(XFR_LEN), rd_xfr_len);
      if (stop)
         apb_write(memtest_pkg::reg_ctrl_addr, 32'h0);
      repeat (next_rand() % 4) @(negedge mem_clk90);   // grant delay
      rd_mem_grant = 1'b1;
      for (int i = 0; i < XFR_LEN; i++) begin
         @(negedge mem_clk90);
         r             = next_rand();
         rd_mem_grant  = 1'b0;
         rd_data_valid = 1'b1;
         rd_data       = good_beat;
         if (bad[i])
            rd_data = good_beat ^ (memtest_pkg::beat_t'(r[7:0] | 8'h01) << (8 * r[9:8]));
      end
      @(negedge mem_clk90);
      rd_data_valid = 1'b0;
   endtask

   task automatic stop_in_burst();
      int n = 0;
      while (!rd_data_valid && n < 100) begin
         @(posedge mem_clk90);
         n++;
      end
      if (!rd_data_valid) begin
         err_count++;
         $display("%s: burst never started, run not cleared", cur_test);
      end
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h0);
   endtask

   // pops every expected row and then expects 0
   task automatic pop_all(input memtest_pkg::reg_t exp_status);
      foreach (exp_rows[i])
         read_expect("fault_row", memtest_pkg::reg_fault_row_addr, exp_rows[i]);
      read_expect("fault_row drained", memtest_pkg::reg_fault_row_addr, '0);
      read_expect("status drained", memtest_pkg::reg_status_addr, exp_status);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = err_count;
      exp_rows.delete();
      mem_rst90 = 1'b1;
      repeat (4) @(negedge mem_clk90);
      mem_rst90 = 1'b0;
   endtask

   task automatic end_test();
      $display("test %s finished, %0d errors", cur_test, err_count - test_errs);
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic test_registers();
      start_test("registers");
      read_expect("ctrl reset", memtest_pkg::reg_ctrl_addr, 32'h0);
      read_expect("status reset", memtest_pkg::reg_status_addr, 32'h1);
      read_expect("pass reset", memtest_pkg::reg_pass_addr, 32'h0);
      read_expect("fault_row reset", memtest_pkg::reg_fault_row_addr, 32'h0);
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h1);
      read_expect("ctrl readback", memtest_pkg::reg_ctrl_addr, 32'h1);
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h0);
      read_expect("unmapped read", 4'h2, 32'h0);
      check_reg("unmapped pslverr", 32'h1, memtest_pkg::reg_t'(last_err));
      apb_write(memtest_pkg::reg_status_addr, 32'h7);
      check_reg("status write pslverr", 32'h0, memtest_pkg::reg_t'(last_err));
      read_expect("status after write", memtest_pkg::reg_status_addr, 32'h1);
      end_test();
   endtask

   task automatic test_clean_scan();
      start_test("clean_scan");
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h1);
      for (int i = 0; i < 8; i++)
         serve_burst(memtest_pkg::row_t'(i % (LAST_ROW + 1)), 8'h00, i == 7);
      read_expect("pass", memtest_pkg::reg_pass_addr, 32'h2);
      read_expect("status", memtest_pkg::reg_status_addr, 32'h1);
      end_test();
   endtask

   task automatic test_fault_log();
      logic [31:0] r;
      logic [7:0]  mask;
      start_test("fault_log");
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h1);
      for (int i = 0; i <= LAST_ROW; i++) begin
         r    = next_rand();
         mask = (r[0] || i == 1) ? (r[15:8] | 8'h81) : 8'h00;
         if (mask != 8'h00)
            exp_rows.push_back(memtest_pkg::row_t'(i));
         serve_burst(memtest_pkg::row_t'(i), mask, i == LAST_ROW);
      end
      pop_all(32'h1);
      end_test();
   endtask

   task automatic test_overflow();
      start_test("overflow");
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h1);
      for (int i = 0; i < 6; i++) begin
         if (i < FIFO_DEPTH)
            exp_rows.push_back(memtest_pkg::row_t'(i % (LAST_ROW + 1)));
         serve_burst(memtest_pkg::row_t'(i % (LAST_ROW + 1)), 8'h01 << (next_rand() % 8), i == 5);
      end
      read_expect("status full", memtest_pkg::reg_status_addr, 32'h6);
      pop_all(32'h5);   // empty with overflow still set
      end_test();
   endtask

   task automatic test_stop();
      int seen = 0;
      start_test("stop");
      apb_write(memtest_pkg::reg_ctrl_addr, 32'h1);
      for (int i = 0; i < LAST_ROW; i++)
         serve_burst(memtest_pkg::row_t'(i), 8'h00, 1'b0);
      // the stopped burst is the last row, so its end completes a pass
      fork
         serve_burst(memtest_pkg::row_t'(LAST_ROW), 8'h00, 1'b0);
         stop_in_burst();
      join
      read_expect("pass after stop", memtest_pkg::reg_pass_addr, 32'h1);
      repeat (200) begin
         @(negedge mem_clk90);
         if (rd_mem_req)
            seen++;
      end
      if (seen != 0) begin
         err_count++;
         $display("%s: rd_mem_req raised after run was cleared", cur_test);
      end
      read_expect("pass after watch", memtest_pkg::reg_pass_addr, 32'h1);
      end_test();
   endtask

   initial begin
      mem_rst90     = 1'b1;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      rd_mem_grant  = 1'b0;
      rd_data_valid = 1'b0;
      rd_data       = '0;
      test_registers();
      test_clean_scan();
      test_fault_log();
      test_overflow();
      test_stop();
      err_count += dut0.u_asserts.fail_count;
      $display("tests 5, checks %0d, errors %0d (assertion failures %0d)",
               check_count, err_count, dut0.u_asserts.fail_count);
      if (err_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
